// File: verilog/lp_filter_macros.svh
`ifndef LP_FILTER_MACROS_SVH
`define LP_FILTER_MACROS_SVH

// sample and coefficient width, sized for one 18x18 DSP multiplier
`define LP_DW 18

// output headroom, gain scale is 2^-(17+LP_SHIFT)
`define LP_SHIFT 2

// filter output width
`define LP_YW (`LP_DW + `LP_SHIFT)

// multiplier result, one guard lsb and one carry msb above the kept product
`define LP_MW (`LP_DW + 2)

// AXI4-Lite coefficient register map, byte addresses
`define LP_AXI_AW 4
`define LP_ADDR_KX_RE 4'h0
`define LP_ADDR_KX_IM 4'h4
`define LP_ADDR_KY_RE 4'h8
`define LP_ADDR_KY_IM 4'hC

`endif

// File: verilog/lp_filter_pkg.sv
`default_nettype none

`include "lp_filter_macros.svh"

package lp_filter_pkg;

	// interleaved complex input, real part when iq is high
	typedef struct packed {
		logic                     iq;
		logic signed [`LP_DW-1:0] data;
	} iq_sample_t;

	// filter output carries LP_SHIFT bits of extra headroom
	typedef struct packed {
		logic                     iq;
		logic signed [`LP_YW-1:0] data;
	} y_sample_t;

	typedef logic signed [`LP_DW-1:0] coef_t;

	// AXI4-Lite channel payloads, valid and ready travel beside them
	typedef struct packed {
		logic [`LP_AXI_AW-1:0] addr;
		logic [2:0]            prot;
	} axil_aw_t;

	typedef struct packed {
		logic [31:0] data;
		logic [3:0]  strb;
	} axil_w_t;

	typedef struct packed {
		logic [1:0] resp;
	} axil_b_t;

	typedef struct packed {
		logic [`LP_AXI_AW-1:0] addr;
		logic [2:0]            prot;
	} axil_ar_t;

	typedef struct packed {
		logic [31:0] data;
		logic [1:0]  resp;
	} axil_r_t;

	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

`default_nettype wire

// File: verilog/lp_coef_regs.sv
`default_nettype none
`timescale 1ns/100ps

`include "lp_filter_macros.svh"

module lp_coef_regs
	import lp_filter_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	input  axil_aw_t aw,
	input  axil_w_t  w,
	input  axil_ar_t ar,
	input  logic     awvalid,
	input  logic     wvalid,
	input  logic     arvalid,
	input  logic     bready,
	input  logic     rready,
	output logic     awready,
	output logic     wready,
	output logic     arready,
	output logic     bvalid,
	output logic     rvalid,
	output axil_b_t  b,
	output axil_r_t  r,
	input  logic     iq,
	output coef_t    kx_sel,
	output coef_t    ky_sel
);
	// most negative code, never stored
	localparam coef_t COEF_MIN = coef_t'(1 << (`LP_DW - 1));

	coef_t kx_re, kx_im, ky_re, ky_im;
	coef_t wr_val, rd_val;
	logic  wr_rdy, rd_rdy;
	logic  wr_fire, rd_fire;
	logic  wr_hit, wr_full, rd_hit;

	// AW and W are taken in the same cycle only
	assign wr_fire = wr_rdy && awvalid && wvalid;
	assign rd_fire = rd_rdy && arvalid;
	assign awready = wr_rdy;
	assign wready  = wr_rdy;
	assign arready = rd_rdy;

	// only full 32-bit writes are honored
	assign wr_full = (w.strb == 4'hf);

	always_comb begin
		wr_val = w.data[`LP_DW-1:0];
		// full-scale negative becomes one step smaller
		if (wr_val == COEF_MIN)
			wr_val = COEF_MIN + coef_t'(1);
		case (aw.addr)
			`LP_ADDR_KX_RE, `LP_ADDR_KX_IM, `LP_ADDR_KY_RE, `LP_ADDR_KY_IM: wr_hit = 1'b1;
			default: wr_hit = 1'b0;
		endcase
	end

	always_comb begin
		rd_hit = 1'b1;
		case (ar.addr)
			`LP_ADDR_KX_RE: rd_val = kx_re;
			`LP_ADDR_KX_IM: rd_val = kx_im;
			`LP_ADDR_KY_RE: rd_val = ky_re;
			`LP_ADDR_KY_IM: rd_val = ky_im;
			default: begin
				rd_hit = 1'b0;
				rd_val = '0;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			kx_re <= '0;
			kx_im <= '0;
			ky_re <= '0;
			ky_im <= '0;
		end else if (wr_fire && wr_hit && wr_full) begin
			case (aw.addr)
				`LP_ADDR_KX_RE: kx_re <= wr_val;
				`LP_ADDR_KX_IM: kx_im <= wr_val;
				`LP_ADDR_KY_RE: ky_re <= wr_val;
				`LP_ADDR_KY_IM: ky_im <= wr_val;
				default: ;
			endcase
		end
	end

	// ready drops while a response waits, returns once it is taken
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_rdy <= 1'b0;
			bvalid <= 1'b0;
			rd_rdy <= 1'b0;
			rvalid <= 1'b0;
		end else begin
			if (wr_fire) begin
				wr_rdy <= 1'b0;
				bvalid <= 1'b1;
			end else if (bvalid && bready) begin
				bvalid <= 1'b0;
				wr_rdy <= 1'b1;
			end else if (!bvalid) begin
				wr_rdy <= 1'b1;
			end
			if (rd_fire) begin
				rd_rdy <= 1'b0;
				rvalid <= 1'b1;
			end else if (rvalid && rready) begin
				rvalid <= 1'b0;
				rd_rdy <= 1'b1;
			end else if (!rvalid) begin
				rd_rdy <= 1'b1;
			end
		end
	end

	// response payloads, held while their valid waits
	always_ff @(posedge clk) begin
		if (wr_fire)
			b.resp <= (wr_hit && wr_full) ? RESP_OKAY : RESP_SLVERR;
		if (rd_fire) begin
			r.data <= {{(32 - `LP_DW){rd_val[`LP_DW-1]}}, rd_val};
			r.resp <= rd_hit ? RESP_OKAY : RESP_SLVERR;
		end
	end

	// pick the half matching the sample now entering the multipliers
	assign kx_sel = iq ? kx_re : kx_im;
	assign ky_sel = iq ? ky_re : ky_im;

	// master keeps each request steady until it is accepted
	a_aw_stable: assert property (@(posedge clk) disable iff (!rst_n)
		awvalid && !awready |=> awvalid && $stable(aw));
	a_w_stable: assert property (@(posedge clk) disable iff (!rst_n)
		wvalid && !wready |=> wvalid && $stable(w));
	a_ar_stable: assert property (@(posedge clk) disable iff (!rst_n)
		arvalid && !arready |=> arvalid && $stable(ar));

	// no coefficient ever reaches the multipliers at full-scale negative
	a_no_min: assert property (@(posedge clk) disable iff (!rst_n)
		kx_re != COEF_MIN && kx_im != COEF_MIN && ky_re != COEF_MIN && ky_im != COEF_MIN);

endmodule

`default_nettype wire

// File: verilog/lp_cmul.sv
`default_nettype none
`timescale 1ns/100ps

`include "lp_filter_macros.svh"

module lp_cmul
	import lp_filter_pkg::*;
(
	input  logic                     clk,
	input  logic                     rst_n,
	input  iq_sample_t               a,
	input  coef_t                    k,
	output logic signed [`LP_MW-1:0] p
);
	// full product width and kept msb slice with one guard bit
	localparam int PW = 2 * `LP_DW;
	localparam int HW = `LP_DW + 1;

	logic [2:0]               iq_sr;
	logic signed [`LP_DW-1:0] a1, a2, m2mux;
	coef_t                    k1;
	logic signed [PW-1:0]     prod1, prod2;
	logic signed [HW-1:0]     prod1_msb, prod2_msb;
	logic signed [HW-1:0]     prod1_d, prod2_d;
	logic signed [`LP_MW-1:0] re_part, im_part;

	// phase tracking through the pipeline
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			iq_sr <= '0;
		else
			iq_sr <= {iq_sr[1:0], a.iq};
	end

	// second multiplier takes the sample from two clocks back on the real phase
	assign m2mux = iq_sr[1] ? a2 : a.data;

	// product1 gives re*re and im*im, product2 gives the cross terms
	always_ff @(posedge clk) begin
		a1      <= a.data;
		a2      <= a1;
		k1      <= k;
		prod1   <= a.data * k;
		prod2   <= m2mux * k1;
		prod1_d <= prod1_msb;
		prod2_d <= prod2_msb;
	end

	// top bits only, full-scale negative squared never happens
	assign prod1_msb = prod1[PW-2:`LP_DW-2];
	assign prod2_msb = prod2[PW-2:`LP_DW-2];

	// guard bits kept through the add, carry lands in the extra msb
	assign re_part = prod1_d - prod1_msb;
	assign im_part = prod2_d + prod2_msb;

	// no output register, the accumulator registers the sum
	assign p = iq_sr[2] ? im_part : re_part;

	// the interleave relies on iq toggling each clock once the pipe is filled
	a_iq_alt: assert property (@(posedge clk) disable iff (!rst_n)
		$past(rst_n, 3) |-> a.iq != $past(a.iq));

endmodule

`default_nettype wire

// File: verilog/lp_accum.sv
`default_nettype none
`timescale 1ns/100ps

`include "lp_filter_macros.svh"

module lp_accum
	import lp_filter_pkg::*;
(
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic signed [`LP_MW-1:0] mx,
	input  logic signed [`LP_MW-1:0] my,
	input  logic                     iq,
	output iq_sample_t               y_fb,
	output y_sample_t                y_out
);
	// state keeps a guard lsb, sum adds one carry bit on top
	localparam int SW = `LP_YW + 1;
	localparam int UW = `LP_YW + 2;

	logic signed [UW-1:0] sum;
	logic signed [SW-1:0] state, state_sat;
	logic                 sum_iq, state_iq;

	// clamp to full scale when the top two sum bits disagree
	always_comb begin
		if (sum[UW-1] == sum[UW-2])
			state_sat = sum[SW-1:0];
		else
			state_sat = {sum[UW-1], {(SW - 1){~sum[UW-1]}}};
	end

	// five-way junction, each multiplier hides two of the terms
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sum      <= '0;
			state    <= '0;
			sum_iq   <= 1'b0;
			state_iq <= 1'b0;
		end else begin
			sum      <= mx + my + state;
			state    <= state_sat;
			// two register stages, so the tag lines up with the next x phase
			sum_iq   <= iq;
			state_iq <= sum_iq;
		end
	end

	always_comb begin
		// ky multiplier sees the top LP_DW bits, gain 2^-LP_SHIFT
		y_fb.iq    = state_iq;
		y_fb.data  = state[SW-1:SW-`LP_DW];
		y_out.iq   = state_iq;
		y_out.data = state[SW-1:1];
	end

	// state sign follows the exact five-term total from two clocks back
	a_no_wrap: assert property (@(posedge clk) disable iff (!rst_n)
		$past(rst_n, 2) |-> state[SW-1] == $past((mx + my + state) < 0, 2));

endmodule

`default_nettype wire

// File: verilog/lp_filter_top.sv
`default_nettype none
`timescale 1ns/100ps

`include "lp_filter_macros.svh"

module lp_filter_top
	import lp_filter_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  axil_aw_t   aw,
	input  axil_w_t    w,
	input  axil_ar_t   ar,
	input  logic       awvalid,
	input  logic       wvalid,
	input  logic       arvalid,
	input  logic       bready,
	input  logic       rready,
	output logic       awready,
	output logic       wready,
	output logic       arready,
	output logic       bvalid,
	output logic       rvalid,
	output axil_b_t    b,
	output axil_r_t    r,
	input  iq_sample_t x_in,
	output y_sample_t  y_out
);
	coef_t                    kx_sel, ky_sel;
	logic signed [`LP_MW-1:0] mx, my;
	iq_sample_t               y_fb;

	// coefficient halves follow the phase of the incoming x sample
	lp_coef_regs u_regs (
		.clk, .rst_n, .aw, .w, .ar, .awvalid, .wvalid, .arvalid, .bready, .rready,
		.awready, .wready, .arready, .bvalid, .rvalid, .b, .r,
		.iq(x_in.iq), .kx_sel, .ky_sel
	);

	// kx*x path
	lp_cmul u_xmul (.clk, .rst_n, .a(x_in), .k(kx_sel), .p(mx));

	// ky*y feedback path, y_fb arrives in the same phase as x_in
	lp_cmul u_ymul (.clk, .rst_n, .a(y_fb), .k(ky_sel), .p(my));

	lp_accum u_accum (.clk, .rst_n, .mx, .my, .iq(x_in.iq), .y_fb, .y_out);

endmodule

`default_nettype wire

// File: tb/lp_filter_model.svh
`ifndef LP_FILTER_MODEL_SVH
`define LP_FILTER_MODEL_SVH

// clamp a real result into the signed output range
function automatic int sat_y(input real v);
	real hi;
	real lo;
	hi = (2.0 ** (`LP_YW - 1)) - 1.0;
	lo = -(2.0 ** (`LP_YW - 1));
	if (v > hi)
		return int'(hi);
	if (v < lo)
		return int'(lo);
	return int'(v);
endfunction

// steady state y = -kx*x*2^SHIFT/ky, or n pairs of kx*x*2^-17 when ky is zero
task automatic steady_state_y(inout test_row_t row);
	real pr, pi, den, qr, qi, n;
	pr = real'(row.kx_re) * real'(row.x_re) - real'(row.kx_im) * real'(row.x_im);
	pi = real'(row.kx_re) * real'(row.x_im) + real'(row.kx_im) * real'(row.x_re);
	if (row.ky_re == 0 && row.ky_im == 0) begin
		n = real'(row.settle / 2);
		row.exp_re = sat_y(pr * n / (2.0 ** 17));
		row.exp_im = sat_y(pi * n / (2.0 ** 17));
	end else begin
		// multiply by conj(ky) over |ky|^2
		den = real'(row.ky_re) * real'(row.ky_re) + real'(row.ky_im) * real'(row.ky_im);
		qr = (pr * real'(row.ky_re) + pi * real'(row.ky_im)) / den;
		qi = (pi * real'(row.ky_re) - pr * real'(row.ky_im)) / den;
		row.exp_re = sat_y(-qr * (2.0 ** `LP_SHIFT));
		row.exp_im = sat_y(-qi * (2.0 ** `LP_SHIFT));
	end
endtask

task automatic check_y(input y_sample_t got, input logic exp_iq, input int exp,
		input int tol, input string what);
	int diff;
	diff = int'(got.data) - exp;
	if (diff < 0)
		diff = -diff;
	if (got.iq !== exp_iq || diff > tol) begin
		$display("Error %0t ns: %s y got %0d iq %0b, expected %0d iq %0b tol %0d",
			$time, what, got.data, got.iq, exp, exp_iq, tol);
		errors++;
	end
endtask

task automatic check_b_resp(input axil_b_t got, input logic [1:0] exp, input string what);
	if (got.resp !== exp) begin
		$display("Error %0t ns: %s bresp %0b, expected %0b", $time, what, got.resp, exp);
		errors++;
	end
endtask

task automatic check_r_resp(input axil_r_t got, input logic [1:0] exp_resp,
		input logic [31:0] exp_data, input string what);
	if (got.resp !== exp_resp || got.data !== exp_data) begin
		$display("Error %0t ns: %s rresp %0b data %h, expected %0b %h",
			$time, what, got.resp, got.data, exp_resp, exp_data);
		errors++;
	end
endtask

task automatic check_coef(input coef_t got, input coef_t exp, input string what);
	if (got !== exp) begin
		$display("Error %0t ns: %s coef %0d, expected %0d", $time, what, got, exp);
		errors++;
	end
endtask

`endif

// File: tb/lp_filter_tb.sv
`default_nettype none
`timescale 1ns/100ps

`include "lp_filter_macros.svh"

module lp_filter_tb
	import lp_filter_pkg::*;
;
	localparam int NFIX = 5;
	localparam int NRAND = 6;
	localparam int NROWS = NFIX + NRAND;

	typedef struct {
		coef_t                    kx_re;
		coef_t                    kx_im;
		coef_t                    ky_re;
		coef_t                    ky_im;
		logic signed [`LP_DW-1:0] x_re;
		logic signed [`LP_DW-1:0] x_im;
		int                       settle;
		int                       exp_re;
		int                       exp_im;
		int                       tol;
	} test_row_t;

	logic       clk, rst_n;
	axil_aw_t   aw;
	axil_w_t    w;
	axil_ar_t   ar;
	logic       awvalid, wvalid, arvalid, bready, rready;
	logic       awready, wready, arready, bvalid, rvalid;
	axil_b_t    b;
	axil_r_t    r;
	iq_sample_t x_in;
	y_sample_t  y_out;

	logic signed [`LP_DW-1:0] x_re, x_im;
	test_row_t                rows [NROWS];
	int                       errors;
	int                       fails;
	longint                   limit_ns;

	`include "lp_filter_model.svh"

	lp_filter_top u_dut (
		.clk, .rst_n, .aw, .w, .ar, .awvalid, .wvalid, .arvalid, .bready, .rready,
		.awready, .wready, .arready, .bvalid, .rvalid, .b, .r, .x_in, .y_out
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// free-running iq stream, real part on iq high
	initial begin
		x_in.iq = 1'b1;
		x_in.data = '0;
		forever begin
			@(posedge clk);
			#2;
			x_in.iq = ~x_in.iq;
			x_in.data = x_in.iq ? x_re : x_im;
		end
	end

	// handshake seen 2 ns after an edge completes at the next edge
	task automatic axi_write(input logic [3:0] addr, input logic [31:0] data,
			input logic [3:0] strb, output axil_b_t resp);
		@(posedge clk);
		#2;
		aw.addr = addr;
		w.data = data;
		w.strb = strb;
		awvalid = 1'b1;
		wvalid = 1'b1;
		while (!(awready && wready)) begin
			@(posedge clk);
			#2;
		end
		@(posedge clk);
		#2;
		awvalid = 1'b0;
		wvalid = 1'b0;
		bready = 1'b1;
		while (!bvalid) begin
			@(posedge clk);
			#2;
		end
		resp = b;
		@(posedge clk);
		#2;
		bready = 1'b0;
	endtask

	task automatic axi_read(input logic [3:0] addr, output axil_r_t resp);
		@(posedge clk);
		#2;
		ar.addr = addr;
		arvalid = 1'b1;
		while (!arready) begin
			@(posedge clk);
			#2;
		end
		@(posedge clk);
		#2;
		arvalid = 1'b0;
		rready = 1'b1;
		while (!rvalid) begin
			@(posedge clk);
			#2;
		end
		resp = r;
		@(posedge clk);
		#2;
		rready = 1'b0;
	endtask

	task automatic write_ok(input logic [3:0] addr, input coef_t k, input string what);
		axil_b_t br;
		axi_write(addr, 32'(signed'(k)), 4'hf, br);
		check_b_resp(br, RESP_OKAY, what);
	endtask

	task automatic read_expect(input logic [3:0] addr, input logic [1:0] exp_resp,
			input logic [31:0] exp_data, input string what);
		axil_r_t rr;
		axi_read(addr, rr);
		check_r_resp(rr, exp_resp, exp_data, what);
		check_coef(coef_t'(rr.data[`LP_DW-1:0]), coef_t'(exp_data[`LP_DW-1:0]), what);
	endtask

	task automatic report(input int num, input string name, input int errs_before);
		if (errors != errs_before)
			fails++;
		$display("test %0d %s: %s", num, name, (errors != errs_before) ? "FAIL" : "ok");
	endtask

	task automatic fill_table();
		coef_t kx[NFIX][4];
		int    xv[NFIX][2];
		int    st[NFIX];
		int    tl[NFIX];
		// zero input, real settle, complex settle, positive and negative saturation
		kx = '{'{5000, 0, 0, 0}, '{20000, 0, -32768, 0}, '{15000, -9000, -30000, 8000},
			'{100000, 0, -256, 0}, '{100000, 0, -256, 0}};
		xv = '{'{0, 0}, '{30000, -12000}, '{20000, 15000},
			'{100000, 100000}, '{-100000, -100000}};
		st = '{200, 600, 800, 200, 200};
		tl = '{0, 48, 64, 2, 2};
		for (int i = 0; i < NFIX; i++) begin
			rows[i].kx_re = kx[i][0];
			rows[i].kx_im = kx[i][1];
			rows[i].ky_re = kx[i][2];
			rows[i].ky_im = kx[i][3];
			rows[i].x_re = xv[i][0];
			rows[i].x_im = xv[i][1];
			rows[i].settle = st[i];
			rows[i].tol = tl[i];
		end
		// ky real part kept strongly negative so the loop settles unsaturated
		for (int i = NFIX; i < NROWS; i++) begin
			rows[i].kx_re = coef_t'(int'($urandom % 8192) - 4096);
			rows[i].kx_im = coef_t'(int'($urandom % 8192) - 4096);
			rows[i].ky_re = coef_t'(-(16384 + int'($urandom % 32768)));
			rows[i].ky_im = coef_t'(int'($urandom % 16384) - 8192);
			rows[i].x_re = int'($urandom % 32768) - 16384;
			rows[i].x_im = int'($urandom % 32768) - 16384;
			rows[i].settle = 800;
			rows[i].tol = 96;
		end
		for (int i = 0; i < NROWS; i++)
			steady_state_y(rows[i]);
	endtask

	// run length follows the table
	initial begin
		wait (limit_ns > 0);
		#(limit_ns);
		$display("timeout: the DUT did not finish the tests in time");
		$display("Verification failed");
		$finish;
	end

	initial begin
		int      e0;
		int      sum_settle;
		axil_b_t br;
		void'($urandom(32'h7123));
		$timeformat(-9, 0, "", 0);
		errors = 0;
		fails = 0;
		limit_ns = 0;
		rst_n = 1'b0;
		aw = '0;
		w = '0;
		ar = '0;
		awvalid = 1'b0;
		wvalid = 1'b0;
		arvalid = 1'b0;
		bready = 1'b0;
		rready = 1'b0;
		x_re = '0;
		x_im = '0;
		fill_table();
		sum_settle = 0;
		for (int i = 0; i < NROWS; i++)
			sum_settle += rows[i].settle;
		limit_ns = longint'(sum_settle + 200 * (NROWS + 2)) * 40;
		repeat (5) @(posedge clk);
		#2;
		rst_n = 1'b1;

		// reset state
		e0 = errors;
		@(negedge clk);
		check_y(y_out, 1'b0, 0, 0, "reset");
		if (bvalid || rvalid) begin
			$display("Error %0t ns: response valid high after reset", $time);
			errors++;
		end
		read_expect(`LP_ADDR_KX_RE, RESP_OKAY, 32'h0, "reset kx_re");
		read_expect(`LP_ADDR_KX_IM, RESP_OKAY, 32'h0, "reset kx_im");
		read_expect(`LP_ADDR_KY_RE, RESP_OKAY, 32'h0, "reset ky_re");
		read_expect(`LP_ADDR_KY_IM, RESP_OKAY, 32'h0, "reset ky_im");
		report(0, "reset", e0);

		// register access, clamp and error responses
		e0 = errors;
		write_ok(`LP_ADDR_KX_RE, -1000, "write kx_re");
		read_expect(`LP_ADDR_KX_RE, RESP_OKAY, 32'hFFFFFC18, "read kx_re");
		axi_write(`LP_ADDR_KY_IM, 32'hABC12345, 4'hf, br);
		check_b_resp(br, RESP_OKAY, "write ky_im");
		read_expect(`LP_ADDR_KY_IM, RESP_OKAY, 32'h00012345, "read ky_im");
		axi_write(`LP_ADDR_KY_RE, 32'hFFFE0000, 4'hf, br);
		check_b_resp(br, RESP_OKAY, "write ky_re min");
		read_expect(`LP_ADDR_KY_RE, RESP_OKAY, 32'hFFFE0001, "read ky_re clamp");
		axi_write(4'h2, 32'h1234, 4'hf, br);
		check_b_resp(br, RESP_SLVERR, "unmapped write");
		read_expect(4'h1, RESP_SLVERR, 32'h0, "unmapped read");
		axi_write(`LP_ADDR_KX_IM, 32'h5555, 4'h3, br);
		check_b_resp(br, RESP_SLVERR, "partial write");
		read_expect(`LP_ADDR_KX_IM, RESP_OKAY, 32'h0, "kx_im unchanged");
		report(1, "registers", e0);

		for (int i = 0; i < NROWS; i++) begin
			e0 = errors;
			write_ok(`LP_ADDR_KX_RE, rows[i].kx_re, "row kx_re");
			write_ok(`LP_ADDR_KX_IM, rows[i].kx_im, "row kx_im");
			write_ok(`LP_ADDR_KY_RE, rows[i].ky_re, "row ky_re");
			write_ok(`LP_ADDR_KY_IM, rows[i].ky_im, "row ky_im");
			@(negedge clk);
			x_re = rows[i].x_re;
			x_im = rows[i].x_im;
			repeat (rows[i].settle) @(negedge clk);
			// line up on the real phase, then take the pair
			while (y_out.iq !== 1'b1)
				@(negedge clk);
			check_y(y_out, 1'b1, rows[i].exp_re, rows[i].tol, "real");
			@(negedge clk);
			check_y(y_out, 1'b0, rows[i].exp_im, rows[i].tol, "imag");
			report(i + 2, (i < NFIX) ? "fixed row" : "random row", e0);
		end

		$display("tests %0d, failing %0d, errors %0d", NROWS + 2, fails, errors);
		if (errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+verilog
+incdir+tb
verilog/lp_filter_pkg.sv
verilog/lp_coef_regs.sv
verilog/lp_cmul.sv
verilog/lp_accum.sv
verilog/lp_filter_top.sv
tb/lp_filter_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the lp_filter testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f filelist.f --top-module lp_filter_tb -o lp_filter_sim > build.log 2>&1 \
	|| { echo "build error, see build.log"; exit 1; }

./obj_dir/lp_filter_sim > sim.log 2>&1 || true

grep -q "Verification passed" sim.log \
	&& { echo "simulation PASS"; exit 0; } \
	|| { echo "simulation FAIL, see sim.log"; exit 1; }
